//--- Bender.yml
package:
  name: stream_stat_monitor

sources:
  - common/stat_mon_pkg.sv
  - src/stream_stat_collector.sv
  - report/stat_report_serializer.sv
  - report/byte_skid_buffer.sv
  - src/stream_stat_monitor.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/tb_stat_checker.sv
      - test/tb_stream_stat_monitor.sv

//--- common/stat_mon_pkg.sv
package stat_mon_pkg;

    // width of one running count in the report
    typedef logic [31:0] stat_count_t;

    // caller supplied label, echoed at the head of each report
    typedef logic [15:0] stat_tag_t;

    // one byte of the serial report stream
    typedef logic [7:0] report_byte_t;

    // byte position inside a report, 0 to 13
    typedef logic [3:0] report_idx_t;

    // counts frozen at the trigger
    // field order matches the order they leave in the report
    typedef struct packed {
        stat_count_t tick_count;
        stat_count_t byte_count;
        stat_count_t frame_count;
    } stat_snapshot_t;

    // one report byte with its end marker
    typedef struct packed {
        report_byte_t data;
        logic         last;
    } report_beat_t;

    // serializer FSM
    typedef enum logic {
        REPORT_IDLE,
        REPORT_SEND
    } report_state_t;

    // tag + three counts, two plus 3 x 4 bytes
    localparam int REPORT_LEN = 14;

    // index of the byte that carries tlast
    localparam report_idx_t REPORT_LAST_IDX = report_idx_t'(REPORT_LEN - 1);

endpackage

//--- filelist.f
common/stat_mon_pkg.sv
src/stream_stat_collector.sv
report/stat_report_serializer.sv
report/byte_skid_buffer.sv
src/stream_stat_monitor.sv
test/tb_clock_gen.sv
test/tb_stat_checker.sv
test/tb_stream_stat_monitor.sv

//--- report/byte_skid_buffer.sv
module byte_skid_buffer (
    input  logic                        clk,
    input  logic                        rst,
    input  stat_mon_pkg::report_beat_t  beat,
    input  logic                        beat_valid,
    output logic                        beat_ready,
    output stat_mon_pkg::report_byte_t  rpt_tdata,
    output logic                        rpt_tvalid,
    output logic                        rpt_tlast,
    input  logic                        rpt_tready
);

    stat_mon_pkg::report_beat_t out_q;
    stat_mon_pkg::report_beat_t spare_q;

    logic out_valid_q;
    logic spare_valid_q;
    logic ready_q;
    logic ready_d;
    logic in_to_out;
    logic in_to_spare;
    logic spare_to_out;

    // ready next cycle if the sink drains now, both registers are empty,
    // or the spare is empty and will not be filled this cycle
    assign ready_d = rpt_tready
                   || (!spare_valid_q && !out_valid_q)
                   || (!spare_valid_q && !beat_valid);

    // spare only ever holds data while ready_q is low
    assign in_to_out    = ready_q && (rpt_tready || !out_valid_q);
    assign in_to_spare  = ready_q && !rpt_tready && out_valid_q;
    assign spare_to_out = !ready_q && rpt_tready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ready_q       <= 1'b0;
            out_valid_q   <= 1'b0;
            spare_valid_q <= 1'b0;
        end else begin
            ready_q <= ready_d;
            if (in_to_out) begin
                out_valid_q <= beat_valid;
            end else if (in_to_spare) begin
                spare_valid_q <= beat_valid;
            end else if (spare_to_out) begin
                out_valid_q   <= spare_valid_q;
                spare_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_to_out) begin
            out_q <= beat;
        end else if (in_to_spare) begin
            spare_q <= beat;
        end else if (spare_to_out) begin
            out_q <= spare_q;
        end
    end

    assign beat_ready = ready_q;
    assign rpt_tvalid = out_valid_q;
    assign rpt_tdata  = out_q.data;
    assign rpt_tlast  = out_q.last;

    // no byte is taken while ready is low, so one offered then would be lost
    offer_only_when_ready: assert property (
        @(posedge clk) disable iff (rst)
        beat_valid |-> ready_q
    ) else $error("beat offered while buffer not ready");

    hold_under_backpressure: assert property (
        @(posedge clk) disable iff (rst)
        rpt_tvalid && !rpt_tready |=> rpt_tvalid && $stable(rpt_tdata) && $stable(rpt_tlast)
    ) else $error("report byte changed while stalled");

endmodule

//--- report/stat_report_serializer.sv
module stat_report_serializer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          trigger,
    input  stat_mon_pkg::stat_tag_t       tag,
    input  stat_mon_pkg::stat_snapshot_t  snapshot,
    output logic                          capture,
    output logic                          busy,
    output stat_mon_pkg::report_beat_t    beat,
    output logic                          beat_valid,
    input  logic                          beat_ready
);

    stat_mon_pkg::report_state_t state_q;
    stat_mon_pkg::report_state_t state_d;
    stat_mon_pkg::report_idx_t   idx_q;
    stat_mon_pkg::report_idx_t   idx_d;
    stat_mon_pkg::report_idx_t   byte_sel;
    stat_mon_pkg::stat_tag_t     tag_q;

    // whole report as one vector, byte 0 in the top bits
    logic [stat_mon_pkg::REPORT_LEN*8-1:0] report_word;
    logic last_byte;

    assign busy = (state_q == stat_mon_pkg::REPORT_SEND);

    // trigger is a plain level, taken whenever the FSM is idle
    assign capture = (state_q == stat_mon_pkg::REPORT_IDLE) && trigger;

    // ready is registered in the buffer, so offering only when it
    // is high means every offered byte is taken
    assign beat_valid = busy && beat_ready;

    assign report_word = {tag_q, snapshot};
    assign last_byte   = (idx_q == stat_mon_pkg::REPORT_LAST_IDX);

    // msb first, so byte 0 sits at the highest slice
    assign byte_sel = stat_mon_pkg::REPORT_LAST_IDX - idx_q;

    always_comb begin
        beat.data = report_word[8*byte_sel +: 8];
        beat.last = last_byte;
    end

    always_comb begin
        state_d = state_q;
        idx_d   = idx_q;
        case (state_q)
            stat_mon_pkg::REPORT_IDLE: begin
                if (trigger) begin
                    state_d = stat_mon_pkg::REPORT_SEND;
                    idx_d   = '0;
                end
            end
            stat_mon_pkg::REPORT_SEND: begin
                if (beat_valid) begin
                    idx_d = idx_q + 1'b1;
                    // busy drops on the edge that hands over the last byte
                    if (last_byte) begin
                        state_d = stat_mon_pkg::REPORT_IDLE;
                    end
                end
            end
            default: begin
                state_d = stat_mon_pkg::REPORT_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= stat_mon_pkg::REPORT_IDLE;
            idx_q   <= '0;
        end else begin
            state_q <= state_d;
            idx_q   <= idx_d;
        end
    end

    // tag held for the whole report
    always_ff @(posedge clk) begin
        if (capture) begin
            tag_q <= tag;
        end
    end

    // a held trigger must not restart the counters mid-report,
    // so capture follows an idle cycle or the hand-over of the last byte
    no_capture_while_busy: assert property (
        @(posedge clk) disable iff (rst)
        capture |-> !$past(busy) || $past(beat_valid && last_byte)
    ) else $error("capture pulsed during a report");

endmodule

//--- src/stream_stat_collector.sv
module stream_stat_collector #(
    parameter int DATA_WIDTH = 64
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [DATA_WIDTH/8-1:0]       mon_tkeep,
    input  logic                          mon_tvalid,
    input  logic                          mon_tready,
    input  logic                          mon_tlast,
    input  logic                          capture,
    output stat_mon_pkg::stat_snapshot_t  snapshot
);

    localparam int KEEP_WIDTH = DATA_WIDTH / 8;

    // byte lanes offered by the bus every cycle
    localparam stat_mon_pkg::stat_count_t KEEP_INC = stat_mon_pkg::stat_count_t'(KEEP_WIDTH);

    stat_mon_pkg::stat_count_t tick_q;
    stat_mon_pkg::stat_count_t byte_q;
    stat_mon_pkg::stat_count_t frame_q;
    stat_mon_pkg::stat_count_t tick_d;
    stat_mon_pkg::stat_count_t byte_d;
    stat_mon_pkg::stat_count_t frame_d;
    stat_mon_pkg::stat_count_t beat_bytes;
    stat_mon_pkg::stat_snapshot_t snap_q;

    logic beat_acc;
    logic frame_start;
    logic in_frame_q;
    logic in_frame_d;

    function automatic stat_mon_pkg::stat_count_t keep_popcount(
        input logic [KEEP_WIDTH-1:0] keep
    );
        stat_mon_pkg::stat_count_t n;
        n = '0;
        for (int i = 0; i < KEEP_WIDTH; i++) begin
            n = n + stat_mon_pkg::stat_count_t'(keep[i]);
        end
        return n;
    endfunction

    assign beat_acc = mon_tvalid && mon_tready;

    // first accepted beat outside a frame, single-beat frames included
    assign frame_start = beat_acc && !in_frame_q;

    assign beat_bytes = beat_acc ? keep_popcount(mon_tkeep) : '0;

    always_comb begin
        in_frame_d = in_frame_q;
        if (beat_acc) begin
            in_frame_d = !mon_tlast;
        end
    end

    // on capture the counters restart from zero but still take
    // this cycle's increment, so no cycle or beat is dropped
    always_comb begin
        tick_d  = (capture ? '0 : tick_q) + KEEP_INC;
        byte_d  = (capture ? '0 : byte_q) + beat_bytes;
        frame_d = (capture ? '0 : frame_q) + stat_mon_pkg::stat_count_t'(frame_start);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tick_q     <= '0;
            byte_q     <= '0;
            frame_q    <= '0;
            in_frame_q <= 1'b0;
        end else begin
            tick_q     <= tick_d;
            byte_q     <= byte_d;
            frame_q    <= frame_d;
            in_frame_q <= in_frame_d;
        end
    end

    // pre-edge counts frozen for the report
    always_ff @(posedge clk) begin
        if (capture) begin
            snap_q.tick_count  <= tick_q;
            snap_q.byte_count  <= byte_q;
            snap_q.frame_count <= frame_q;
        end
    end

    assign snapshot = snap_q;

    in_frame_needs_beat: assert property (
        @(posedge clk) disable iff (rst)
        !beat_acc |=> $stable(in_frame_q)
    ) else $error("in-frame flag changed without an accepted beat");

endmodule

//--- src/stream_stat_monitor.sv
module stream_stat_monitor #(
    parameter int DATA_WIDTH = 64
) (
    input  logic                        clk,
    input  logic                        rst,
    // monitored link, observed only
    input  logic [DATA_WIDTH/8-1:0]     mon_tkeep,
    input  logic                        mon_tvalid,
    input  logic                        mon_tready,
    input  logic                        mon_tlast,
    input  stat_mon_pkg::stat_tag_t     tag,
    input  logic                        trigger,
    output logic                        busy,
    // report stream
    output stat_mon_pkg::report_byte_t  rpt_tdata,
    output logic                        rpt_tvalid,
    output logic                        rpt_tlast,
    input  logic                        rpt_tready
);

    stat_mon_pkg::stat_snapshot_t snapshot;
    stat_mon_pkg::report_beat_t   beat;

    logic capture;
    logic beat_valid;
    logic beat_ready;

    stream_stat_collector #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_collector (
        .clk        (clk),
        .rst        (rst),
        .mon_tkeep  (mon_tkeep),
        .mon_tvalid (mon_tvalid),
        .mon_tready (mon_tready),
        .mon_tlast  (mon_tlast),
        .capture    (capture),
        .snapshot   (snapshot)
    );

    stat_report_serializer u_serializer (
        .clk        (clk),
        .rst        (rst),
        .trigger    (trigger),
        .tag        (tag),
        .snapshot   (snapshot),
        .capture    (capture),
        .busy       (busy),
        .beat       (beat),
        .beat_valid (beat_valid),
        .beat_ready (beat_ready)
    );

    byte_skid_buffer u_skid (
        .clk        (clk),
        .rst        (rst),
        .beat       (beat),
        .beat_valid (beat_valid),
        .beat_ready (beat_ready),
        .rpt_tdata  (rpt_tdata),
        .rpt_tvalid (rpt_tvalid),
        .rpt_tlast  (rpt_tlast),
        .rpt_tready (rpt_tready)
    );

endmodule

//--- test/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD = 20;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // reset held over three rising edges, released just after the third
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

//--- test/tb_stat_checker.sv
module tb_stat_checker (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  mon_tkeep,
    input  logic        mon_tvalid,
    input  logic        mon_tready,
    input  logic        mon_tlast,
    input  logic [15:0] tag,
    input  logic        trigger,
    input  logic        busy,
    input  logic [7:0]  rpt_tdata,
    input  logic        rpt_tvalid,
    input  logic        rpt_tlast,
    input  logic        rpt_tready,
    output int          report_count,
    output int          error_count
);

    timeunit 1ns;
    timeprecision 100ps;

    // byte lanes of a 64-bit link
    localparam int KEEP_BYTES = 8;

    logic [31:0] tick_sh;
    logic [31:0] byte_sh;
    logic [31:0] frame_sh;
    logic [31:0] byte_inc;
    logic        frame_inc;
    logic        in_frame_sh;
    logic        beat_acc;
    logic        accept_q;
    logic [7:0]  exp_bytes[$];
    int          byte_idx;
    int          report_errs;

    initial begin
        report_count = 0;
        error_count  = 0;
        byte_idx     = 0;
        report_errs  = 0;
    end

    // tag, ticks, bytes, frames, each msb first
    task automatic push_report(input logic [15:0] t, input logic [31:0] ticks,
                               input logic [31:0] bytes, input logic [31:0] frames);
        logic [111:0] word;
        word = {t, ticks, bytes, frames};
        for (int i = stat_mon_pkg::REPORT_LEN - 1; i >= 0; i--) begin
            exp_bytes.push_back(word[8*i +: 8]);
        end
    endtask

    task automatic check_byte();
        logic [7:0] exp_data;
        logic       exp_last;
        if (exp_bytes.size() == 0) begin
            $display("report byte 0x%02h arrived with no accepted trigger pending", rpt_tdata);
            error_count++;
        end else begin
            exp_data = exp_bytes.pop_front();
            exp_last = (byte_idx == stat_mon_pkg::REPORT_LEN - 1);
            if (rpt_tdata !== exp_data) begin
                $display("ERR rpt_tdata report %0d byte %0d: got 0x%02h expected 0x%02h",
                         report_count, byte_idx, rpt_tdata, exp_data);
                report_errs++;
                error_count++;
            end
            if (rpt_tlast !== exp_last) begin
                $display("ERR rpt_tlast report %0d byte %0d: got 0x%0h expected 0x%0h",
                         report_count, byte_idx, rpt_tlast, exp_last);
                report_errs++;
                error_count++;
            end
            byte_idx++;
            if (byte_idx == stat_mon_pkg::REPORT_LEN) begin
                $display("report %0d finished with %0d mismatches", report_count, report_errs);
                report_count++;
                byte_idx    = 0;
                report_errs = 0;
            end
        end
    endtask

    // shadow counters follow the link one edge at a time
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            tick_sh     = '0;
            byte_sh     = '0;
            frame_sh    = '0;
            in_frame_sh = 1'b0;
            accept_q    = 1'b0;
        end else begin
            // busy rises on the edge that accepted the trigger
            if (accept_q && busy !== 1'b1) begin
                $display("ERR busy after accepted trigger: got 0x%0h expected 0x1", busy);
                error_count++;
            end
            // once idle, only the two buffer registers may still hold report bytes
            if (!busy && exp_bytes.size() > 2) begin
                $display("busy was low with %0d report bytes still unsent", exp_bytes.size());
                error_count++;
            end
            if (rpt_tvalid && rpt_tready) begin
                check_byte();
            end
            beat_acc  = mon_tvalid && mon_tready;
            byte_inc  = beat_acc ? 32'($countones(mon_tkeep)) : 32'd0;
            frame_inc = beat_acc && !in_frame_sh;
            if (beat_acc) begin
                in_frame_sh = !mon_tlast;
            end
            // accepted trigger freezes the pre-edge counts
            if (trigger && !busy) begin
                push_report(tag, tick_sh, byte_sh, frame_sh);
                tick_sh  = KEEP_BYTES;
                byte_sh  = byte_inc;
                frame_sh = 32'(frame_inc);
                accept_q = 1'b1;
            end else begin
                tick_sh  = tick_sh + KEEP_BYTES;
                byte_sh  = byte_sh + byte_inc;
                frame_sh = frame_sh + 32'(frame_inc);
                accept_q = 1'b0;
            end
        end
    end

endmodule

//--- test/tb_stream_stat_monitor.sv
module tb_stream_stat_monitor;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DATA_WIDTH     = 64;
    localparam int NUM_ROWS       = 10;
    localparam int BEAT_TIMEOUT   = 64;
    localparam int ACCEPT_TIMEOUT = 8;
    localparam int BUSY_TIMEOUT   = 400;
    localparam int DRAIN_TIMEOUT  = 800;

    // trigger modes of a row
    localparam logic [1:0] TRIG_NONE  = 2'd0;
    localparam logic [1:0] TRIG_AFTER = 2'd1;
    localparam logic [1:0] TRIG_MID   = 2'd2;

    typedef struct packed {
        logic [7:0] beats;
        logic [7:0] last_keep;
        logic [7:0] gap;
        logic [7:0] duty;
        logic [1:0] trig;
    } stim_row_t;

    logic        clk;
    logic        rst;
    logic [7:0]  mon_tkeep;
    logic        mon_tvalid;
    logic        mon_tready;
    logic        mon_tlast;
    logic [15:0] tag;
    logic        trigger;
    logic        busy;
    logic [7:0]  rpt_tdata;
    logic        rpt_tvalid;
    logic        rpt_tlast;
    logic        rpt_tready;
    int          report_count;
    int          error_count;

    stim_row_t stim [NUM_ROWS];
    int        rpt_duty;
    int        tb_errors;
    int        triggers_sent;
    int        waited;
    logic      last_beat;

    tb_clock_gen clock_gen (
        .clk (clk),
        .rst (rst)
    );

    stream_stat_monitor #(
        .DATA_WIDTH (DATA_WIDTH)
    ) uut (
        .clk        (clk),
        .rst        (rst),
        .mon_tkeep  (mon_tkeep),
        .mon_tvalid (mon_tvalid),
        .mon_tready (mon_tready),
        .mon_tlast  (mon_tlast),
        .tag        (tag),
        .trigger    (trigger),
        .busy       (busy),
        .rpt_tdata  (rpt_tdata),
        .rpt_tvalid (rpt_tvalid),
        .rpt_tlast  (rpt_tlast),
        .rpt_tready (rpt_tready)
    );

    tb_stat_checker stat_check (
        .clk          (clk),
        .rst          (rst),
        .mon_tkeep    (mon_tkeep),
        .mon_tvalid   (mon_tvalid),
        .mon_tready   (mon_tready),
        .mon_tlast    (mon_tlast),
        .tag          (tag),
        .trigger      (trigger),
        .busy         (busy),
        .rpt_tdata    (rpt_tdata),
        .rpt_tvalid   (rpt_tvalid),
        .rpt_tlast    (rpt_tlast),
        .rpt_tready   (rpt_tready),
        .report_count (report_count),
        .error_count  (error_count)
    );

    // beats, last keep, gap, report duty in percent, trigger mode
    task automatic load_table();
        stim[0] = '{8'd1, 8'h01, 8'd0, 8'd100, TRIG_NONE};
        stim[1] = '{8'd3, 8'h0f, 8'd2, 8'd100, TRIG_AFTER};
        stim[2] = '{8'd1, 8'hff, 8'd1, 8'd60,  TRIG_NONE};
        stim[3] = '{8'd4, 8'h07, 8'd0, 8'd60,  TRIG_MID};
        stim[4] = '{8'd2, 8'h80, 8'd3, 8'd30,  TRIG_NONE};
        stim[5] = '{8'd1, 8'h03, 8'd0, 8'd30,  TRIG_AFTER};
        stim[6] = '{8'd5, 8'hff, 8'd2, 8'd50,  TRIG_NONE};
        stim[7] = '{8'd2, 8'h11, 8'd1, 8'd25,  TRIG_MID};
        stim[8] = '{8'd3, 8'h3f, 8'd0, 8'd75,  TRIG_AFTER};
        stim[9] = '{8'd1, 8'hc0, 8'd4, 8'd100, TRIG_AFTER};
    endtask

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
        mon_tready = 1'($urandom % 2);
        rpt_tready = (($urandom % 100) < rpt_duty);
    endtask

    // hold the beat until the link accepts it
    task automatic drive_beat(input logic [7:0] keep, input logic last);
        int tries;
        tries      = 0;
        mon_tvalid = 1'b1;
        mon_tkeep  = keep;
        mon_tlast  = last;
        while (!mon_tready && tries < BEAT_TIMEOUT) begin
            next_cycle();
            tries++;
        end
        if (!mon_tready) begin
            $display("beat on the monitored link was never accepted");
            tb_errors++;
        end
        next_cycle();
        mon_tvalid = 1'b0;
    endtask

    task automatic fire_trigger(input int duty);
        int tries;
        tries = 0;
        while (busy && tries < BUSY_TIMEOUT) begin
            next_cycle();
            tries++;
        end
        if (busy) begin
            $display("busy never fell before the next trigger");
            tb_errors++;
        end
        rpt_duty = duty;
        trigger  = 1'b1;
        tries    = 0;
        next_cycle();
        while (!busy && tries < ACCEPT_TIMEOUT) begin
            next_cycle();
            tries++;
        end
        if (!busy) begin
            $display("trigger was not accepted while the monitor was idle");
            tb_errors++;
        end else begin
            triggers_sent++;
        end
        // new tag and a held then repeated trigger, all during the report
        tag = tag + 16'h1111;
        next_cycle();
        next_cycle();
        trigger = 1'b0;
        next_cycle();
        trigger = 1'b1;
        next_cycle();
        trigger = 1'b0;
    endtask

    initial begin
        mon_tkeep     = '0;
        mon_tvalid    = 1'b0;
        mon_tready    = 1'b0;
        mon_tlast     = 1'b0;
        tag           = 16'ha5c3;
        trigger       = 1'b0;
        rpt_tready    = 1'b0;
        rpt_duty      = 100;
        tb_errors     = 0;
        triggers_sent = 0;
        void'($urandom(19));
        load_table();

        waited = 0;
        while (rst !== 1'b0 && waited < 20) begin
            next_cycle();
            waited++;
        end

        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int b = 0; b < stim[r].beats; b++) begin
                last_beat = (b == stim[r].beats - 1);
                drive_beat(last_beat ? stim[r].last_keep : 8'hff, last_beat);
                // frame started before this trigger stays in the old interval
                if (b == 0 && stim[r].trig == TRIG_MID) begin
                    fire_trigger(stim[r].duty);
                end
            end
            repeat (stim[r].gap) next_cycle();
            if (stim[r].trig == TRIG_AFTER) begin
                fire_trigger(stim[r].duty);
            end
        end

        waited = 0;
        while (report_count < triggers_sent && waited < DRAIN_TIMEOUT) begin
            next_cycle();
            waited++;
        end
        if (report_count < triggers_sent) begin
            $display("reports still missing when the run ended");
            tb_errors++;
        end

        $display("reports %0d of %0d, checker errors %0d, other failures %0d",
                 report_count, triggers_sent, error_count, tb_errors);
        if (tb_errors == 0 && error_count == 0 && report_count == triggers_sent) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
